/* src/fp_settings.svh */
`ifndef FP_SETTINGS_SVH
`define FP_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////
// channel counts and sample widths
//////////////////////////////////////////////////////////////////////

`define FP_N_ADC 8            // adc channels
`define FP_N_DAC 8            // dac channels
`define FP_N_OUT 8            // router outputs
`define FP_W_ADC 18
`define FP_W_DAC 16
`define FP_WORD_W 16          // one wire-in / wire-out word

// host bus
`define FP_HOST_AW 8
`define FP_HOST_DW 32

// pipes
`define FP_ADC_PIPE_DEPTH 16
`define FP_DAC_PIPE_DEPTH 16
`define FP_FILL_W 8           // fill count as seen in status

//////////////////////////////////////////////////////////////////////
// host address map
//////////////////////////////////////////////////////////////////////

`define FP_WIN_BASE 8'h00
`define FP_WIN_SPAN 32
`define FP_WOUT_BASE 8'h20
`define FP_WOUT_SPAN 8
`define FP_TRIG_BASE 8'h40
`define FP_TRIG_SPAN 5
`define FP_ADC_PIPE_ADDR 8'hA0
`define FP_DAC_PIPE_ADDR 8'hA4
`define FP_STATUS_ADDR 8'hA8

// wire-in slots
`define FP_WIN_ADC_OS 5'd0
`define FP_WIN_OSF_ACTIVATE 5'd1
`define FP_WIN_OSF_CYCLE_DELAY 5'd2
`define FP_WIN_OSF_OSM 5'd3
`define FP_WIN_OSF_UPDATE_EN 5'd4
`define FP_WIN_PID_LOCK_EN 5'd5
`define FP_WIN_PID_SETPOINT 5'd6
`define FP_WIN_PID_P_COEF 5'd7
`define FP_WIN_PID_I_COEF 5'd8
`define FP_WIN_PID_D_COEF 5'd9
`define FP_WIN_PID_UPDATE_EN 5'd10
`define FP_WIN_RTR_SRC_SEL 5'd11
`define FP_WIN_RTR_DEST_SEL 5'd12
`define FP_WIN_RTR_OUTPUT_ACTIVE 5'd13
`define FP_WIN_OPP_MIN0 5'd14
`define FP_WIN_OPP_MIN1 5'd15
`define FP_WIN_OPP_MIN2 5'd16
`define FP_WIN_OPP_MAX0 5'd17
`define FP_WIN_OPP_MAX1 5'd18
`define FP_WIN_OPP_MAX2 5'd19
`define FP_WIN_OPP_INIT0 5'd20
`define FP_WIN_OPP_INIT1 5'd21
`define FP_WIN_OPP_INIT2 5'd22
`define FP_WIN_OPP_UPDATE_EN 5'd23
`define FP_N_WIN 24           // slots actually backed by a register

// trigger-in slots
`define FP_TRIG_ADC_CSTART 3'd0
`define FP_TRIG_PID_CLEAR 3'd1
`define FP_TRIG_DAC_REF_SET 3'd2
`define FP_TRIG_MODULE_UPDATE 3'd3
`define FP_TRIG_SYS_RESET 3'd4

`endif

/* src/fp_pkg.sv */
`include "fp_settings.svh"

package fp_pkg;

	//////////////////////////////////////////////////////////////////////
	// host bus
	//////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic wr;                              // one-cycle write strobe
		logic rd;                              // one-cycle read strobe
		logic [`FP_HOST_AW-1:0] addr;
		logic [`FP_HOST_DW-1:0] wdata;
	} host_req_t;

	typedef struct packed {
		logic valid;                           // one cycle after rd
		logic [`FP_HOST_DW-1:0] rdata;
	} host_rsp_t;

	// address regions
	typedef enum logic [2:0] {
		region_win,
		region_wout,
		region_trig,
		region_adc_pipe,
		region_dac_pipe,
		region_status,
		region_none
	} fp_region_e;

	//////////////////////////////////////////////////////////////////////
	// downstream configuration
	//////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic [`FP_N_ADC-1:0] activate;
		logic [15:0] cycle_delay;
		logic [5:0] osm;                       // oversample ratio
		logic [`FP_N_ADC-1:0] update_en;
	} osf_cfg_t;

	typedef struct packed {
		logic [`FP_N_ADC-1:0] lock_en;
		logic [15:0] setpoint;
		logic signed [15:0] p_coef;
		logic signed [15:0] i_coef;
		logic signed [15:0] d_coef;
		logic [`FP_N_ADC-1:0] update_en;
	} pid_cfg_t;

	typedef struct packed {
		logic [3:0] src_sel;
		logic [3:0] dest_sel;
		logic [`FP_N_OUT-1:0] output_active;
	} rtr_cfg_t;

	typedef struct packed {
		logic [47:0] min;
		logic [47:0] max;
		logic [47:0] init;
		logic [`FP_N_OUT-1:0] update_en;
	} opp_cfg_t;

	// one-cycle pulses
	typedef struct packed {
		logic adc_cstart;
		logic [`FP_N_ADC-1:0] pid_clear;     // per channel
		logic dac_ref_set;
		logic module_update;
		logic sys_reset;
	} trig_t;

	// pipe items
	typedef struct packed {
		logic [2:0] chan;
		logic [`FP_W_ADC-1:0] sample;
	} adc_item_t;

	typedef struct packed {
		logic [2:0] chan;
		logic [`FP_W_DAC-1:0] sample;
	} dac_item_t;

endpackage

/* src/fp_host_ctrl.sv */
`timescale 1ns/1ns
`include "fp_settings.svh"

module fp_host_ctrl (
	input  logic clk50_in,
	input  logic rst,
	input  fp_pkg::host_req_t host_req,
	output fp_pkg::host_rsp_t host_rsp,
	output logic win_wr,
	output logic [4:0] win_idx,
	output logic trig_wr,
	output logic [2:0] trig_idx,
	output logic [`FP_WORD_W-1:0] wdata,
	input  logic [`FP_WORD_W-1:0] win_rdata,
	input  logic [`FP_WORD_W-1:0] wout_rdata,
	output logic [2:0] wout_idx,
	output logic adc_pop,
	output logic dac_pop,
	input  fp_pkg::adc_item_t adc_head,
	input  fp_pkg::dac_item_t dac_head,
	input  logic adc_empty,
	input  logic dac_empty,
	input  logic adc_ovf,
	input  logic dac_ovf,
	input  logic [`FP_FILL_W-1:0] adc_fill,
	input  logic [`FP_FILL_W-1:0] dac_fill
);

	fp_pkg::fp_region_e req_region;
	fp_pkg::fp_region_e rd_region_q;         // region of the pending read
	logic rd_q;
	logic [`FP_HOST_DW-1:0] reg_word, reg_word_q;
	fp_pkg::adc_item_t adc_head_q;
	fp_pkg::dac_item_t dac_head_q;
	logic adc_hit_q, dac_hit_q;              // pipe had data at request time

	// offset of a from base, checked against span
	function automatic logic in_range(input logic [`FP_HOST_AW-1:0] a,
		input logic [`FP_HOST_AW-1:0] base, input int span);
		logic [`FP_HOST_AW-1:0] off;
		off = a - base;                      // wraps high when a < base
		return int'(off) < span;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// request decode
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		if (in_range(host_req.addr, `FP_WIN_BASE, `FP_WIN_SPAN))
			req_region = fp_pkg::region_win;
		else if (in_range(host_req.addr, `FP_WOUT_BASE, `FP_WOUT_SPAN))
			req_region = fp_pkg::region_wout;
		else if (in_range(host_req.addr, `FP_TRIG_BASE, `FP_TRIG_SPAN))
			req_region = fp_pkg::region_trig;
		else if (host_req.addr == `FP_ADC_PIPE_ADDR)
			req_region = fp_pkg::region_adc_pipe;
		else if (host_req.addr == `FP_DAC_PIPE_ADDR)
			req_region = fp_pkg::region_dac_pipe;
		else if (host_req.addr == `FP_STATUS_ADDR)
			req_region = fp_pkg::region_status;
		else
			req_region = fp_pkg::region_none;
	end

	assign win_wr   = host_req.wr && req_region == fp_pkg::region_win;
	assign trig_wr  = host_req.wr && req_region == fp_pkg::region_trig;
	assign win_idx  = host_req.addr[4:0];
	assign trig_idx = host_req.addr[2:0];
	assign wout_idx = host_req.addr[2:0];
	assign wdata    = host_req.wdata[`FP_WORD_W-1:0];  // upper half unused

	// pop only what is there
	assign adc_pop = host_req.rd && req_region == fp_pkg::region_adc_pipe && !adc_empty;
	assign dac_pop = host_req.rd && req_region == fp_pkg::region_dac_pipe && !dac_empty;

	// register sources sampled in the request cycle
	always_comb begin
		reg_word = '0;
		case (req_region)
			fp_pkg::region_win:  reg_word[`FP_WORD_W-1:0] = win_rdata;
			fp_pkg::region_wout: reg_word[`FP_WORD_W-1:0] = wout_rdata;
			fp_pkg::region_status: begin
				reg_word[0]     = adc_ovf;
				reg_word[1]     = dac_ovf;
				reg_word[15:8]  = adc_fill;
				reg_word[23:16] = dac_fill;
			end
			default: reg_word = '0;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// read response, one cycle late
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk50_in) begin
		if (rst) begin
			rd_q        <= 1'b0;
			rd_region_q <= fp_pkg::region_none;
		end else begin
			rd_q <= host_req.rd;
			if (host_req.rd)
				rd_region_q <= req_region;
		end
	end

	always_ff @(posedge clk50_in) begin
		if (host_req.rd) begin
			reg_word_q <= reg_word;
			adc_head_q <= adc_head;      // fwft head, popped this cycle
			dac_head_q <= dac_head;
			adc_hit_q  <= !adc_empty;
			dac_hit_q  <= !dac_empty;
		end
	end

	always_comb begin
		host_rsp.valid = rd_q;
		host_rsp.rdata = '0;             // trig and unmapped read zero
		case (rd_region_q)
			fp_pkg::region_win, fp_pkg::region_wout, fp_pkg::region_status:
				host_rsp.rdata = reg_word_q;
			fp_pkg::region_adc_pipe:
				if (adc_hit_q) begin
					host_rsp.rdata[$bits(fp_pkg::adc_item_t)-1:0] = adc_head_q;
					host_rsp.rdata[`FP_HOST_DW-1] = 1'b1;     // item present
				end
			fp_pkg::region_dac_pipe:
				if (dac_hit_q) begin
					host_rsp.rdata[$bits(fp_pkg::dac_item_t)-1:0] = dac_head_q;
					host_rsp.rdata[`FP_HOST_DW-1] = 1'b1;
				end
			default: host_rsp.rdata = '0;
		endcase
	end

	// host must never issue both strobes
	assert property (@(posedge clk50_in) disable iff (rst) !(host_req.wr && host_req.rd));

	// a pop needs data, and the answer then carries the present bit
	assert property (@(posedge clk50_in) disable iff (rst)
		adc_pop |-> !adc_empty ##1 host_rsp.rdata[`FP_HOST_DW-1]);
	assert property (@(posedge clk50_in) disable iff (rst)
		dac_pop |-> !dac_empty ##1 host_rsp.rdata[`FP_HOST_DW-1]);

endmodule

/* src/fp_param_regs.sv */
`timescale 1ns/1ns
`include "fp_settings.svh"

module fp_param_regs (
	input  logic clk50_in,
	input  logic rst,
	input  logic win_wr,
	input  logic [4:0] win_idx,
	input  logic [`FP_WORD_W-1:0] wdata,
	output logic [`FP_WORD_W-1:0] win_rdata,
	output fp_pkg::osf_cfg_t osf_cfg,
	output fp_pkg::pid_cfg_t pid_cfg,
	output fp_pkg::rtr_cfg_t rtr_cfg,
	output fp_pkg::opp_cfg_t opp_cfg,
	output logic [2:0] adc_os
);

	logic [`FP_WORD_W-1:0] win_q [`FP_N_WIN];   // one word per wire-in
	logic idx_ok;

	assign idx_ok = int'(win_idx) < `FP_N_WIN;   // slots above read zero

	always_ff @(posedge clk50_in) begin
		if (rst) begin
			for (int i = 0; i < `FP_N_WIN; i++)
				win_q[i] <= '0;
		end else if (win_wr && idx_ok) begin
			win_q[win_idx] <= wdata;
		end
	end

	assign win_rdata = idx_ok ? win_q[win_idx] : '0;   // full stored word

	//////////////////////////////////////////////////////////////////////
	// pack words into unit configs
	//////////////////////////////////////////////////////////////////////

	assign adc_os = win_q[`FP_WIN_ADC_OS][2:0];

	// oversample filter
	assign osf_cfg.activate    = win_q[`FP_WIN_OSF_ACTIVATE][`FP_N_ADC-1:0];
	assign osf_cfg.cycle_delay = win_q[`FP_WIN_OSF_CYCLE_DELAY];
	assign osf_cfg.osm         = win_q[`FP_WIN_OSF_OSM][5:0];
	assign osf_cfg.update_en   = win_q[`FP_WIN_OSF_UPDATE_EN][`FP_N_ADC-1:0];

	// pid core
	assign pid_cfg.lock_en   = win_q[`FP_WIN_PID_LOCK_EN][`FP_N_ADC-1:0];
	assign pid_cfg.setpoint  = win_q[`FP_WIN_PID_SETPOINT];
	assign pid_cfg.p_coef    = win_q[`FP_WIN_PID_P_COEF];
	assign pid_cfg.i_coef    = win_q[`FP_WIN_PID_I_COEF];
	assign pid_cfg.d_coef    = win_q[`FP_WIN_PID_D_COEF];
	assign pid_cfg.update_en = win_q[`FP_WIN_PID_UPDATE_EN][`FP_N_ADC-1:0];

	// router
	assign rtr_cfg.src_sel       = win_q[`FP_WIN_RTR_SRC_SEL][3:0];
	assign rtr_cfg.dest_sel      = win_q[`FP_WIN_RTR_DEST_SEL][3:0];
	assign rtr_cfg.output_active = win_q[`FP_WIN_RTR_OUTPUT_ACTIVE][`FP_N_OUT-1:0];

	// output preprocessor, 48 bit limits low word first
	assign opp_cfg.min = {win_q[`FP_WIN_OPP_MIN2], win_q[`FP_WIN_OPP_MIN1],
		win_q[`FP_WIN_OPP_MIN0]};
	assign opp_cfg.max = {win_q[`FP_WIN_OPP_MAX2], win_q[`FP_WIN_OPP_MAX1],
		win_q[`FP_WIN_OPP_MAX0]};
	assign opp_cfg.init = {win_q[`FP_WIN_OPP_INIT2], win_q[`FP_WIN_OPP_INIT1],
		win_q[`FP_WIN_OPP_INIT0]};
	assign opp_cfg.update_en = win_q[`FP_WIN_OPP_UPDATE_EN][`FP_N_OUT-1:0];

endmodule

/* src/fp_trigger_bank.sv */
`timescale 1ns/1ns
`include "fp_settings.svh"

module fp_trigger_bank (
	input  logic clk50_in,
	input  logic rst,
	input  logic trig_wr,
	input  logic [2:0] trig_idx,
	input  logic [`FP_WORD_W-1:0] wdata,
	output fp_pkg::trig_t trig
);

	logic [3:0] scalar;                      // single-bit triggers

	// pulses last one cycle unless rewritten
	always_ff @(posedge clk50_in) begin
		if (rst) begin
			trig <= '0;
		end else begin
			trig <= '0;
			if (trig_wr) begin
				case (trig_idx)
					`FP_TRIG_ADC_CSTART:    trig.adc_cstart    <= wdata[0];
					`FP_TRIG_PID_CLEAR:     trig.pid_clear     <= wdata[`FP_N_ADC-1:0];
					`FP_TRIG_DAC_REF_SET:   trig.dac_ref_set   <= wdata[0];
					`FP_TRIG_MODULE_UPDATE: trig.module_update <= wdata[0];
					`FP_TRIG_SYS_RESET:     trig.sys_reset     <= wdata[0];
					default: trig <= '0;
				endcase
			end
		end
	end

	assign scalar = {trig.adc_cstart, trig.dac_ref_set, trig.module_update, trig.sys_reset};

	// no scalar trigger stays high two cycles running
	assert property (@(posedge clk50_in) disable iff (rst) (scalar & $past(scalar)) == '0);

endmodule

/* src/fp_data_tap.sv */
`timescale 1ns/1ns
`include "fp_settings.svh"

module fp_data_tap (
	input  logic clk50_in,
	input  logic rst,
	input  logic [`FP_N_ADC-1:0] adc_data_valid,
	input  logic [`FP_W_ADC-1:0] adc_data_a,
	input  logic [`FP_W_ADC-1:0] adc_data_b,
	input  logic [`FP_N_DAC-1:0] opp_dac_data_valid,
	input  logic [`FP_W_DAC-1:0] opp_dac_data0,
	input  logic [2:0] wout_idx,
	output logic [`FP_WORD_W-1:0] wout_rdata,
	output logic adc_push,
	output fp_pkg::adc_item_t adc_item,
	output logic dac_push,
	output fp_pkg::dac_item_t dac_item
);

	localparam int HALF = `FP_N_ADC / 2;

	logic [`FP_W_ADC-1:0] adc_q [`FP_N_ADC];   // latest sample per channel
	logic [2:0] adc_sel, dac_sel;

	//////////////////////////////////////////////////////////////////////
	// wire-out channel registers
	//////////////////////////////////////////////////////////////////////

	// bus a feeds the lower half, bus b the upper half
	for (genvar i = 0; i < HALF; i++) begin : g_pair
		always_ff @(posedge clk50_in) begin
			if (rst) begin
				adc_q[i]      <= '0;
				adc_q[i+HALF] <= '0;
			end else if (adc_data_valid[i]) begin
				adc_q[i] <= adc_data_a;
			end else if (adc_data_valid[i+HALF]) begin
				adc_q[i+HALF] <= adc_data_b;
			end
		end
	end

	assign wout_rdata = adc_q[wout_idx][`FP_W_ADC-1:`FP_W_ADC-`FP_WORD_W];   // bits 17:2

	//////////////////////////////////////////////////////////////////////
	// pipe items
	//////////////////////////////////////////////////////////////////////

	// lowest set valid bit wins
	always_comb begin
		adc_sel = '0;
		for (int k = `FP_N_ADC - 1; k >= 0; k--)
			if (adc_data_valid[k])
				adc_sel = k[2:0];
		dac_sel = '0;
		for (int k = `FP_N_DAC - 1; k >= 0; k--)
			if (opp_dac_data_valid[k])
				dac_sel = k[2:0];
	end

	always_ff @(posedge clk50_in) begin
		if (rst) begin
			adc_push <= 1'b0;
			dac_push <= 1'b0;
		end else begin
			adc_push <= |adc_data_valid;
			dac_push <= |opp_dac_data_valid;
		end
	end

	always_ff @(posedge clk50_in) begin
		if (|adc_data_valid) begin
			adc_item.chan   <= adc_sel;
			adc_item.sample <= (int'(adc_sel) < HALF) ? adc_data_a : adc_data_b;
		end
		if (|opp_dac_data_valid) begin
			dac_item.chan   <= dac_sel;
			dac_item.sample <= opp_dac_data0;       // single dac bus
		end
	end

endmodule

/* src/fp_pipe_fifo.sv */
`timescale 1ns/1ns
`include "fp_settings.svh"

module fp_pipe_fifo #(
	parameter type item_t = logic [7:0],
	parameter int DEPTH = 16
) (
	input  logic clk50_in,
	input  logic rst,
	input  logic clear,                       // sys_reset trigger
	input  logic push,
	input  item_t push_item,
	input  logic pop,
	output item_t head,
	output logic empty,
	output logic ovf,
	output logic [`FP_FILL_W-1:0] fill
);

	localparam int AW = $clog2(DEPTH);

	item_t mem [DEPTH];
	logic [AW-1:0] wr_ptr, rd_ptr;
	logic full, do_push, do_pop;

	assign full    = int'(fill) == DEPTH;
	assign empty   = fill == '0;
	assign do_push = push && !full;          // full drops the item
	assign do_pop  = pop && !empty;
	assign head    = mem[rd_ptr];            // first word falls through

	always_ff @(posedge clk50_in) begin
		if (rst || clear) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill   <= '0;
			ovf    <= 1'b0;
		end else begin
			if (do_push)
				wr_ptr <= (int'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (int'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
			if (push && full)
				ovf <= 1'b1;                   // sticky until clear
			case ({do_push, do_pop})
				2'b10:   fill <= fill + 1'b1;
				2'b01:   fill <= fill - 1'b1;
				default: fill <= fill;
			endcase
		end
	end

	always_ff @(posedge clk50_in) begin
		if (do_push)
			mem[wr_ptr] <= push_item;
	end

	assert property (@(posedge clk50_in) disable iff (rst) int'(fill) <= DEPTH);

endmodule

/* src/frontpanel_interface.sv */
`timescale 1ns/1ns
`include "fp_settings.svh"

module frontpanel_interface (
	input  logic clk50_in,
	input  logic rst,
	input  fp_pkg::host_req_t host_req,
	output fp_pkg::host_rsp_t host_rsp,
	input  logic [`FP_N_ADC-1:0] adc_data_valid,
	input  logic [`FP_W_ADC-1:0] adc_data_a,
	input  logic [`FP_W_ADC-1:0] adc_data_b,
	input  logic [`FP_N_DAC-1:0] opp_dac_data_valid,
	input  logic [`FP_W_DAC-1:0] opp_dac_data0,
	output logic [2:0] adc_os,
	output logic adc_cstart,
	output fp_pkg::osf_cfg_t osf_cfg,
	output fp_pkg::pid_cfg_t pid_cfg,
	output fp_pkg::rtr_cfg_t rtr_cfg,
	output fp_pkg::opp_cfg_t opp_cfg,
	output logic [`FP_N_ADC-1:0] pid_clear,
	output logic dac_ref_set,
	output logic module_update,
	output logic sys_reset
);

	// host ctrl <-> register banks
	logic win_wr, trig_wr;
	logic [4:0] win_idx;
	logic [2:0] trig_idx, wout_idx;
	logic [`FP_WORD_W-1:0] wdata, win_rdata, wout_rdata;
	fp_pkg::trig_t trig;

	// data tap <-> pipes <-> host ctrl
	logic adc_push, dac_push, adc_pop, dac_pop;
	fp_pkg::adc_item_t adc_item, adc_head;
	fp_pkg::dac_item_t dac_item, dac_head;
	logic adc_empty, dac_empty, adc_ovf, dac_ovf;
	logic [`FP_FILL_W-1:0] adc_fill, dac_fill;

	//////////////////////////////////////////////////////////////////////
	// blocks
	//////////////////////////////////////////////////////////////////////

	fp_host_ctrl i_host_ctrl (
		.clk50_in, .rst, .host_req, .host_rsp,
		.win_wr, .win_idx, .trig_wr, .trig_idx, .wdata,
		.win_rdata, .wout_rdata, .wout_idx,
		.adc_pop, .dac_pop, .adc_head, .dac_head,
		.adc_empty, .dac_empty, .adc_ovf, .dac_ovf, .adc_fill, .dac_fill
	);

	fp_param_regs i_param_regs (
		.clk50_in, .rst, .win_wr, .win_idx, .wdata, .win_rdata,
		.osf_cfg, .pid_cfg, .rtr_cfg, .opp_cfg, .adc_os
	);

	fp_trigger_bank i_trigger_bank (
		.clk50_in, .rst, .trig_wr, .trig_idx, .wdata, .trig
	);

	fp_data_tap i_data_tap (
		.clk50_in, .rst, .adc_data_valid, .adc_data_a, .adc_data_b,
		.opp_dac_data_valid, .opp_dac_data0, .wout_idx, .wout_rdata,
		.adc_push, .adc_item, .dac_push, .dac_item
	);

	// bulk pipes, cleared by rst or the sys_reset trigger
	fp_pipe_fifo #(.item_t(fp_pkg::adc_item_t), .DEPTH(`FP_ADC_PIPE_DEPTH)) i_adc_pipe (
		.clk50_in, .rst, .clear(trig.sys_reset),
		.push(adc_push), .push_item(adc_item), .pop(adc_pop),
		.head(adc_head), .empty(adc_empty), .ovf(adc_ovf), .fill(adc_fill)
	);

	fp_pipe_fifo #(.item_t(fp_pkg::dac_item_t), .DEPTH(`FP_DAC_PIPE_DEPTH)) i_dac_pipe (
		.clk50_in, .rst, .clear(trig.sys_reset),
		.push(dac_push), .push_item(dac_item), .pop(dac_pop),
		.head(dac_head), .empty(dac_empty), .ovf(dac_ovf), .fill(dac_fill)
	);

	// trigger pulses out to the units
	assign adc_cstart    = trig.adc_cstart;
	assign pid_clear     = trig.pid_clear;
	assign dac_ref_set   = trig.dac_ref_set;
	assign module_update = trig.module_update;
	assign sys_reset     = trig.sys_reset;

endmodule

/* tb/tb_fp_tasks.svh */
`ifndef TB_FP_TASKS_SVH
`define TB_FP_TASKS_SVH

//////////////////////////////////////////////////////////////////////
// host bus access
//////////////////////////////////////////////////////////////////////

// single-cycle write strobe, no answer on the bus
task automatic host_write(input logic [7:0] addr, input logic [31:0] data);
	@(posedge clk50_in);
	#1;
	host_req.wr = 1'b1;
	host_req.addr = addr;
	host_req.wdata = data;
	@(posedge clk50_in);
	#1;
	host_req = '0;
endtask

task automatic host_read(input logic [7:0] addr, output logic [31:0] data);
	int waited;
	@(posedge clk50_in);
	#1;
	host_req.rd = 1'b1;
	host_req.addr = addr;
	@(posedge clk50_in);
	#1;
	host_req = '0;
	waited = 0;
	while (!host_rsp.valid) begin               // answer due right away
		if (waited == RSP_TIMEOUT)
			report_error($sformatf("no read response for address %0h", addr));
		@(posedge clk50_in);
		#1;
		waited++;
	end
	// exactly one cycle after the strobe
	assert (waited == 0) else
		report_error($sformatf("read answer for address %0h came %0d cycles late",
			addr, waited));
	data = host_rsp.rdata;
endtask

task automatic check_eq(input string test, input logic [159:0] expected,
	input logic [159:0] actual);
	assert (actual === expected) else
		report_error($sformatf("FAILED %s expected %0h actual %0h", test, expected, actual));
endtask

task automatic read_expect(input string test, input logic [7:0] addr,
	input logic [31:0] expected);
	logic [31:0] got;
	host_read(addr, got);
	check_eq(test, 160'(expected), 160'(got));
endtask

// one cycle of adc / dac valid strobes
task automatic push_samples(input logic [`FP_N_ADC-1:0] adc_valid,
	input logic [`FP_W_ADC-1:0] a, input logic [`FP_W_ADC-1:0] b,
	input logic [`FP_N_DAC-1:0] dac_valid, input logic [`FP_W_DAC-1:0] d);
	@(posedge clk50_in);
	#1;
	adc_data_valid = adc_valid;
	adc_data_a = a;
	adc_data_b = b;
	opp_dac_data_valid = dac_valid;
	opp_dac_data0 = d;
	@(posedge clk50_in);
	#1;
	adc_data_valid = '0;
	opp_dac_data_valid = '0;
endtask

task automatic clear_pipes();
	host_write(`FP_TRIG_BASE + 8'(`FP_TRIG_SYS_RESET), 32'h1);
endtask

// reads each expected word in order, then one empty read
task automatic drain_pipe(input string test, input logic is_dac);
	int n;
	logic [31:0] word;
	n = 0;
	while ((is_dac ? dac_exp.size() : adc_exp.size()) > 0) begin
		word = is_dac ? dac_exp.pop_front() : adc_exp.pop_front();
		read_expect($sformatf("%s_item_%0d", test, n),
			is_dac ? `FP_DAC_PIPE_ADDR : `FP_ADC_PIPE_ADDR, word);
		n++;
	end
	read_expect({test, "_empty"}, is_dac ? `FP_DAC_PIPE_ADDR : `FP_ADC_PIPE_ADDR, 32'h0);
endtask

//////////////////////////////////////////////////////////////////////
// expected values
//////////////////////////////////////////////////////////////////////

// narrow fields take the low bits of their word
task automatic compare_cfg(input string test);
	fp_pkg::osf_cfg_t osf;
	fp_pkg::pid_cfg_t pid;
	fp_pkg::rtr_cfg_t rtr;
	fp_pkg::opp_cfg_t opp;
	osf.activate    = win_model[`FP_WIN_OSF_ACTIVATE][`FP_N_ADC-1:0];
	osf.cycle_delay = win_model[`FP_WIN_OSF_CYCLE_DELAY];
	osf.osm         = win_model[`FP_WIN_OSF_OSM][5:0];
	osf.update_en   = win_model[`FP_WIN_OSF_UPDATE_EN][`FP_N_ADC-1:0];
	pid.lock_en     = win_model[`FP_WIN_PID_LOCK_EN][`FP_N_ADC-1:0];
	pid.setpoint    = win_model[`FP_WIN_PID_SETPOINT];
	pid.p_coef      = win_model[`FP_WIN_PID_P_COEF];
	pid.i_coef      = win_model[`FP_WIN_PID_I_COEF];
	pid.d_coef      = win_model[`FP_WIN_PID_D_COEF];
	pid.update_en   = win_model[`FP_WIN_PID_UPDATE_EN][`FP_N_ADC-1:0];
	rtr.src_sel     = win_model[`FP_WIN_RTR_SRC_SEL][3:0];
	rtr.dest_sel    = win_model[`FP_WIN_RTR_DEST_SEL][3:0];
	rtr.output_active = win_model[`FP_WIN_RTR_OUTPUT_ACTIVE][`FP_N_OUT-1:0];
	// 48 bit limits, word 0 is the low word
	opp.min  = {win_model[`FP_WIN_OPP_MIN2], win_model[`FP_WIN_OPP_MIN1],
		win_model[`FP_WIN_OPP_MIN0]};
	opp.max  = {win_model[`FP_WIN_OPP_MAX2], win_model[`FP_WIN_OPP_MAX1],
		win_model[`FP_WIN_OPP_MAX0]};
	opp.init = {win_model[`FP_WIN_OPP_INIT2], win_model[`FP_WIN_OPP_INIT1],
		win_model[`FP_WIN_OPP_INIT0]};
	opp.update_en = win_model[`FP_WIN_OPP_UPDATE_EN][`FP_N_OUT-1:0];
	check_eq({test, "_adc_os"}, 160'(win_model[`FP_WIN_ADC_OS][2:0]), 160'(adc_os));
	check_eq({test, "_osf"}, 160'(osf), 160'(osf_cfg));
	check_eq({test, "_pid"}, 160'(pid), 160'(pid_cfg));
	check_eq({test, "_rtr"}, 160'(rtr), 160'(rtr_cfg));
	check_eq({test, "_opp"}, 160'(opp), 160'(opp_cfg));
endtask

function automatic logic [11:0] trig_now();
	return {adc_cstart, pid_clear, dac_ref_set, module_update, sys_reset};
endfunction

// same bit order as trig_now
function automatic logic [11:0] expected_pulses(input logic [2:0] idx,
	input logic [`FP_WORD_W-1:0] data);
	case (idx)
		`FP_TRIG_ADC_CSTART:    return {data[0], 11'h0};
		`FP_TRIG_PID_CLEAR:     return {1'b0, data[`FP_N_ADC-1:0], 3'h0};
		`FP_TRIG_DAC_REF_SET:   return {9'h0, data[0], 2'h0};
		`FP_TRIG_MODULE_UPDATE: return {10'h0, data[0], 1'b0};
		default:                return {11'h0, data[0]};     // sys_reset
	endcase
endfunction

//////////////////////////////////////////////////////////////////////
// directed tests
//////////////////////////////////////////////////////////////////////

task automatic reset_defaults();
	for (int i = 0; i < `FP_N_WIN; i++)
		win_model[i] = '0;
	compare_cfg("reset_cfg");
	check_eq("reset_triggers", 160'(0), 160'(trig_now()));
	check_eq("reset_rsp_valid", 160'(0), 160'(host_rsp.valid));
	read_expect("reset_status", `FP_STATUS_ADDR, 32'h0);
	read_expect("reset_adc_pipe", `FP_ADC_PIPE_ADDR, 32'h0);   // bit 31 clear
	read_expect("reset_dac_pipe", `FP_DAC_PIPE_ADDR, 32'h0);
endtask

task automatic wire_in_roundtrip();
	logic [`FP_WORD_W-1:0] word;
	for (int i = 0; i < `FP_N_WIN; i++) begin
		word = 16'($urandom);
		host_write(`FP_WIN_BASE + 8'(i), {16'h0, word});
		win_model[i] = word;
		compare_cfg($sformatf("wire_in_%0d", i));   // one cycle after the write
	end
	for (int i = 0; i < `FP_N_WIN; i++)
		read_expect($sformatf("wire_in_readback_%0d", i), `FP_WIN_BASE + 8'(i),
			{16'h0, win_model[i]});
endtask

task automatic wire_out_latch();
	logic [`FP_W_ADC-1:0] a, b;
	for (int ch = 0; ch < `FP_N_ADC; ch++) begin
		a = 18'($urandom);
		b = 18'($urandom);
		push_samples(8'(1) << ch, a, b, '0, '0);
		chan_model[ch] = (ch < `FP_N_ADC / 2) ? a : b;   // upper half comes from bus b
	end
	read_expect("wire_out_fill_before", `FP_STATUS_ADDR, 32'h0000_0800);
	for (int ch = 0; ch < `FP_N_ADC; ch++)
		read_expect($sformatf("wire_out_%0d", ch), `FP_WOUT_BASE + 8'(ch),
			{16'h0, chan_model[ch][17:2]});
	read_expect("wire_out_fill_after", `FP_STATUS_ADDR, 32'h0000_0800);  // untouched
endtask

task automatic trigger_pulses();
	logic [`FP_WORD_W-1:0] data;
	logic [11:0] exp_bits, bits;
	int cnt [12];
	for (int idx = 0; idx < `FP_TRIG_SPAN; idx++) begin
		for (int pass = 0; pass < 2; pass++) begin
			data = 16'($urandom);
			data[0] = (pass == 0);               // both polarities of bit 0
			exp_bits = expected_pulses(3'(idx), data);
			check_eq($sformatf("trigger_%0d_idle", idx), 160'(0), 160'(trig_now()));
			host_write(`FP_TRIG_BASE + 8'(idx), {16'h0, data});
			check_eq($sformatf("trigger_%0d_first_cycle", idx), 160'(exp_bits),
				160'(trig_now()));
			for (int k = 0; k < 12; k++)
				cnt[k] = 0;
			for (int c = 0; c < 6; c++) begin   // window of six cycles
				bits = trig_now();
				for (int k = 0; k < 12; k++)
					if (bits[k])
						cnt[k]++;
				@(posedge clk50_in);
				#1;
			end
			for (int k = 0; k < 12; k++)
				check_eq($sformatf("trigger_%0d_bit_%0d_count", idx, k),
					160'(exp_bits[k]), 160'(cnt[k]));
		end
	end
endtask

task automatic pipe_ordering();
	logic [2:0] ach, dch;
	logic [`FP_W_ADC-1:0] a, b;
	logic [`FP_W_DAC-1:0] d;
	clear_pipes();
	read_expect("pipes_cleared", `FP_STATUS_ADDR, 32'h0);
	for (int i = 0; i < 6; i++) begin
		ach = 3'($urandom);
		dch = 3'($urandom);
		a = 18'($urandom);
		b = 18'($urandom);
		d = 16'($urandom);
		push_samples(8'(1) << ach, a, b, (i < 5) ? (8'(1) << dch) : 8'h0, d);
		adc_exp.push_back({1'b1, 10'h0, ach, (ach < `FP_N_ADC / 2) ? a : b});
		if (i < 5)
			dac_exp.push_back({1'b1, 12'h0, dch, d});
	end
	read_expect("pipes_fill", `FP_STATUS_ADDR, {8'h0, 8'd5, 8'd6, 8'h0});
	drain_pipe("adc_pipe", 1'b0);
	drain_pipe("dac_pipe", 1'b1);
	read_expect("pipes_drained", `FP_STATUS_ADDR, 32'h0);
endtask

task automatic overflow_and_sys_reset();
	logic [2:0] ach;
	logic [`FP_W_ADC-1:0] a, b;
	for (int i = 0; i < `FP_ADC_PIPE_DEPTH + 3; i++) begin
		ach = 3'($urandom);
		a = 18'($urandom);
		b = 18'($urandom);
		push_samples(8'(1) << ach, a, b, '0, '0);
		if (i < `FP_ADC_PIPE_DEPTH)              // the last three are dropped
			adc_exp.push_back({1'b1, 10'h0, ach, (ach < `FP_N_ADC / 2) ? a : b});
	end
	read_expect("overflow_status", `FP_STATUS_ADDR,
		{16'h0, 8'(`FP_ADC_PIPE_DEPTH), 8'h01});
	drain_pipe("overflow_adc", 1'b0);
	read_expect("overflow_sticky", `FP_STATUS_ADDR, 32'h0000_0001);
	// refill both pipes a little before the reset trigger
	for (int i = 0; i < 3; i++)
		push_samples(8'h01, 18'($urandom), 18'($urandom), 8'h80, 16'($urandom));
	read_expect("refill_status", `FP_STATUS_ADDR, 32'h0003_0301);
	clear_pipes();
	read_expect("sys_reset_status", `FP_STATUS_ADDR, 32'h0);
	read_expect("sys_reset_adc_pipe", `FP_ADC_PIPE_ADDR, 32'h0);
	read_expect("sys_reset_dac_pipe", `FP_DAC_PIPE_ADDR, 32'h0);
	compare_cfg("sys_reset_keeps_cfg");
	for (int i = 0; i < `FP_N_WIN; i++)
		read_expect($sformatf("sys_reset_readback_%0d", i), `FP_WIN_BASE + 8'(i),
			{16'h0, win_model[i]});
endtask

`endif

/* tb/tb_frontpanel_interface.sv */
`timescale 1ns/1ns
`include "fp_settings.svh"

module tb_frontpanel_interface;

	localparam int RSP_TIMEOUT = 50;        // cycles to wait for a read answer
	localparam int WATCHDOG_CYCLES = 40000;

	logic clk50_in;
	logic rst;
	fp_pkg::host_req_t host_req;
	fp_pkg::host_rsp_t host_rsp;
	logic [`FP_N_ADC-1:0] adc_data_valid;
	logic [`FP_W_ADC-1:0] adc_data_a;
	logic [`FP_W_ADC-1:0] adc_data_b;
	logic [`FP_N_DAC-1:0] opp_dac_data_valid;
	logic [`FP_W_DAC-1:0] opp_dac_data0;
	logic [2:0] adc_os;
	logic adc_cstart;
	fp_pkg::osf_cfg_t osf_cfg;
	fp_pkg::pid_cfg_t pid_cfg;
	fp_pkg::rtr_cfg_t rtr_cfg;
	fp_pkg::opp_cfg_t opp_cfg;
	logic [`FP_N_ADC-1:0] pid_clear;
	logic dac_ref_set;
	logic module_update;
	logic sys_reset;

	//////////////////////////////////////////////////////////////////////
	// scoreboard
	//////////////////////////////////////////////////////////////////////

	logic [`FP_WORD_W-1:0] win_model [`FP_N_WIN];   // last word written per slot
	logic [`FP_W_ADC-1:0] chan_model [`FP_N_ADC];   // latest sample per channel
	logic [31:0] adc_exp [$];                       // pipe words in push order
	logic [31:0] dac_exp [$];
	int errors;

	frontpanel_interface i_frontpanel_interface (
		.clk50_in, .rst, .host_req, .host_rsp,
		.adc_data_valid, .adc_data_a, .adc_data_b,
		.opp_dac_data_valid, .opp_dac_data0,
		.adc_os, .adc_cstart, .osf_cfg, .pid_cfg, .rtr_cfg, .opp_cfg,
		.pid_clear, .dac_ref_set, .module_update, .sys_reset
	);

	// 50 MHz nominal, 10 ns here
	initial begin
		clk50_in = 1'b0;
		forever #5 clk50_in = ~clk50_in;
	end

	// print what went wrong, then stop the run
	task automatic report_error(input string what);
		errors++;
		$display("%s", what);
		$display("*** TEST FAILED ***");
		$fatal(1, "stopped at first error");
	endtask

	`include "tb_fp_tasks.svh"

	// guard against a stuck sequence
	initial begin
		for (int i = 0; i < WATCHDOG_CYCLES; i++)
			@(posedge clk50_in);
		report_error("watchdog expired before the test sequence finished");
	end

	//////////////////////////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		void'($urandom(32'hfda6f1cd));
		errors = 0;
		rst = 1'b1;
		host_req = '0;                     // idle bus
		adc_data_valid = '0;
		adc_data_a = '0;
		adc_data_b = '0;
		opp_dac_data_valid = '0;
		opp_dac_data0 = '0;
		repeat (8) @(posedge clk50_in);
		#1;
		rst = 1'b0;

		reset_defaults();
		wire_in_roundtrip();
		wire_out_latch();
		trigger_pulses();
		pipe_ordering();
		overflow_and_sys_reset();

		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

/* all.f */
+incdir+src
+incdir+tb
src/fp_pkg.sv
src/fp_host_ctrl.sv
src/fp_param_regs.sv
src/fp_trigger_bank.sv
src/fp_data_tap.sv
src/fp_pipe_fifo.sv
src/frontpanel_interface.sv
tb/tb_frontpanel_interface.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the front panel testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f \
	--top-module tb_frontpanel_interface --Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qF "*** TEST FAILED ***" sim.log; then
	echo "failure found in sim.log"
	exit 1
fi
exit 0
